// ==== Bender.yml ====
package:
  name: gx_video

export_include_dirs:
  - .

sources:
  - gx_bus_pkg.sv
  - gx_video_pkg.sv
  - gx_reg_decode.sv
  - gx_palette_bank.sv
  - gx_mrer_sync.sv
  - gx_pixel_mux.sv
  - gx_video.sv
  - target: test
    files:
      - tb_gx_video.sv

// ==== gx_bus_pkg.sv ====
`default_nettype none

`include "gx_config.svh"

package gx_bus_pkg;

    // One CPU bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;            // One-clock write strobe
    } cpu_bus_t;

    // Register operation picked by the decoder
    typedef enum logic [2:0] {
        op_none         = 3'd0,
        op_pri_green    = 3'd1,     // Even primary byte
        op_pri_red_blue = 3'd2,     // Odd primary byte
        op_sec_pointer  = 3'd3,     // 7F00
        op_sec_rg       = 3'd4,     // 7F01
        op_sec_commit   = 3'd5,     // 7F02/7F03
        op_mrer         = 3'd6      // 7F8C
    } reg_op_t;

    typedef struct packed {
        reg_op_t                op;
        logic [`GX_IDX_W-1:0]   index;  // Primary entry
        logic [7:0]             data;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== gx_config.svh ====
`ifndef GX_CONFIG_SVH
`define GX_CONFIG_SVH

//////////////////////////////////////////////////
// Palette geometry
//////////////////////////////////////////////////

`define GX_PAL_ENTRIES 32           // Entries per palette
`define GX_IDX_W       5            // Palette index width
`define GX_COMP_W      4            // One color component

//////////////////////////////////////////////////
// CPU address map
//////////////////////////////////////////////////

// Primary palette window 6400-643F
`define GX_PRI_BASE    16'h6400
`define GX_PRI_MASK    16'hFFC0     // Keeps bits above the 64-byte window

`define GX_SEC_PAGE    8'h7F        // Secondary palette and MRER page
`define GX_MRER_ADDR   16'h7F8C     // Mode and ROM enable register

`endif

// ==== gx_mrer_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module gx_mrer_sync (
    input  wire                          clk_sys,
    input  wire                          reset,
    input  wire  gx_bus_pkg::reg_write_t wr,
    input  wire                          hsync,
    input  wire                          plus_mode,        // Strap from the system
    output gx_video_pkg::mrer_t          mrer,
    output gx_video_pkg::video_mode_t    mode,
    output logic                         plus_active,
    output logic                         enhanced_active
);

    gx_video_pkg::mrer_t       staged;
    gx_video_pkg::video_mode_t staged_mode;
    gx_video_pkg::mrer_t       wr_mrer;      // Incoming write as a register value
    logic                      pending;
    logic                      stage;

    // Unknown codes fall back to standard
    function automatic gx_video_pkg::video_mode_t decode_mode(input logic [4:0] code);
        case (code)
            5'h01:   decode_mode = gx_video_pkg::mode_enhanced;
            5'h02:   decode_mode = gx_video_pkg::mode_sprite;
            5'h03:   decode_mode = gx_video_pkg::mode_combined;
            5'h04:   decode_mode = gx_video_pkg::mode_audio;
            5'h0C:   decode_mode = gx_video_pkg::mode_plus;
            default: decode_mode = gx_video_pkg::mode_standard;
        endcase
    endfunction

    // Enhanced flag set for every code that is not standard
    assign wr_mrer.mode_code = wr.data[4:0];
    assign wr_mrer.rom_en    = wr.data[6];
    assign wr_mrer.plus_en   = wr.data[7];
    assign wr_mrer.enhanced  = decode_mode(wr.data[4:0]) != gx_video_pkg::mode_standard;

    // Only a change of mode, ROM enable or plus bit is staged
    assign stage = wr.op == gx_bus_pkg::op_mrer &&
                   {wr_mrer.mode_code, wr_mrer.rom_en, wr_mrer.plus_en} !=
                   {mrer.mode_code, mrer.rom_en, mrer.plus_en};

    always_ff @(posedge clk_sys) begin
        if (stage) begin
            staged      <= wr_mrer;
            staged_mode <= decode_mode(wr.data[4:0]);
        end
    end

    //////////////////////////////////////////////////
    // Apply on hsync
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mrer    <= '0;
            mode    <= gx_video_pkg::mode_standard;
            pending <= 1'b0;
        end else begin
            if (hsync && pending) begin
                mrer    <= staged;
                mode    <= staged_mode;
                pending <= 1'b0;
            end
            if (stage) pending <= 1'b1;     // Fresh write waits for the next hsync
        end
    end

    assign plus_active     = plus_mode | mrer.plus_en;
    assign enhanced_active = mrer.enhanced | plus_mode;

    // Pending write never outlives an hsync unless restaged
    a_pending_clears : assert property (
        @(posedge clk_sys) disable iff (reset)
        pending && hsync && wr.op != gx_bus_pkg::op_mrer |=> !pending
    );

endmodule

`default_nettype wire

// ==== gx_palette_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gx_config.svh"

module gx_palette_bank (
    input  wire                           clk_sys,
    input  wire                           reset,
    input  wire  gx_bus_pkg::reg_write_t  wr,
    input  wire  [`GX_IDX_W-1:0]          rd_a_idx,    // Primary read
    input  wire  [`GX_IDX_W-1:0]          rd_b_idx,    // Secondary read
    output gx_video_pkg::color_t          pri_color,
    output gx_video_pkg::color_t          sec_color
);

    gx_video_pkg::color_t pri_pal [0:`GX_PAL_ENTRIES-1];
    gx_video_pkg::color_t sec_pal [0:`GX_PAL_ENTRIES-1];

    logic [`GX_IDX_W-1:0] pointer;      // Secondary write pointer wrapping at 32
    logic [3:0]           latch_r;
    logic [3:0]           latch_g;

    //////////////////////////////////////////////////
    // Palette writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < `GX_PAL_ENTRIES; i++) begin
                pri_pal[i] <= '0;
                sec_pal[i] <= '0;
            end
            pointer <= '0;
            latch_r <= '0;
            latch_g <= '0;
        end else begin
            case (wr.op)
                gx_bus_pkg::op_pri_green: begin
                    pri_pal[wr.index].green <= wr.data[3:0];
                end
                gx_bus_pkg::op_pri_red_blue: begin
                    pri_pal[wr.index].red  <= wr.data[7:4];
                    pri_pal[wr.index].blue <= wr.data[3:0];
                end
                gx_bus_pkg::op_sec_pointer: pointer <= wr.data[`GX_IDX_W-1:0];
                gx_bus_pkg::op_sec_rg: begin
                    latch_r <= wr.data[7:4];
                    latch_g <= wr.data[3:0];
                end
                gx_bus_pkg::op_sec_commit: begin
                    // Blue sits in the high nibble here
                    sec_pal[pointer] <= '{red: latch_r, green: latch_g, blue: wr.data[7:4]};
                    pointer          <= pointer + 1'b1;
                end
                default: ;                  // MRER and idle cycles
            endcase
        end
    end

    // Asynchronous read ports for the pixel mux
    assign pri_color = pri_pal[rd_a_idx];
    assign sec_color = sec_pal[rd_b_idx];

    // Commit always steps the pointer and wraps 31 to 0
    a_ptr_advance : assert property (
        @(posedge clk_sys) disable iff (reset)
        wr.op == gx_bus_pkg::op_sec_commit |=> pointer == $past(pointer) + 5'd1
    );

endmodule

`default_nettype wire

// ==== gx_pixel_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gx_config.svh"

module gx_pixel_mux (
    input  wire                           clk_sys,
    input  wire                           reset,
    input  wire  gx_video_pkg::pixel_in_t pix,
    input  wire                           plus_active,
    input  wire                           enhanced_active,
    output logic [`GX_IDX_W-1:0]          rd_a_idx,       // To primary palette
    output logic [`GX_IDX_W-1:0]          rd_b_idx,       // To secondary palette
    input  wire  gx_video_pkg::color_t    pri_color,
    input  wire  gx_video_pkg::color_t    sec_color,
    output gx_video_pkg::color_t          rgb_out
);

    logic [`GX_IDX_W-1:0] eff_idx;
    gx_video_pkg::color_t next_color;

    // Sprite pixel wins over background
    assign eff_idx  = pix.sprite_active ? pix.sprite_pixel : pix.color_idx;
    assign rd_a_idx = {1'b0, eff_idx[`GX_IDX_W-2:0]};   // Primary seen as 16 entries
    assign rd_b_idx = eff_idx;

    always_comb begin
        if (plus_active) begin
            next_color = sec_color;                     // Secondary for every pixel in plus
        end else if (enhanced_active && pix.sprite_active) begin
            next_color = sec_color;                     // Sprite over enhanced background
        end else begin
            next_color = pri_color;
        end
    end

    // Output register adds one clock from pixel to pin
    always_ff @(posedge clk_sys) begin
        if (reset) rgb_out <= '0;
        else       rgb_out <= next_color;
    end

endmodule

`default_nettype wire

// ==== gx_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gx_config.svh"

module gx_reg_decode (
    input  wire  gx_bus_pkg::cpu_bus_t   bus,
    output gx_bus_pkg::reg_write_t       wr
);

    logic pri_hit;                  // Inside 6400-643F
    logic sec_hit;                  // Anywhere in the 7F page
    logic mrer_hit;

    assign pri_hit  = (bus.addr & `GX_PRI_MASK) == `GX_PRI_BASE;
    assign sec_hit  = bus.addr[15:8] == `GX_SEC_PAGE;
    assign mrer_hit = bus.addr == `GX_MRER_ADDR;

    always_comb begin
        wr.op    = gx_bus_pkg::op_none;
        wr.index = bus.addr[`GX_IDX_W:1];   // Two bytes per primary entry
        wr.data  = bus.data;

        if (bus.wr) begin
            if (pri_hit) begin
                // Even byte writes green and odd byte writes red and blue
                wr.op = bus.addr[0] ? gx_bus_pkg::op_pri_red_blue
                                    : gx_bus_pkg::op_pri_green;
            end else if (mrer_hit) begin
                wr.op = gx_bus_pkg::op_mrer;
            end else if (sec_hit) begin
                if (bus.addr[7:0] == 8'h00) begin
                    wr.op = gx_bus_pkg::op_sec_pointer;
                end else if (bus.addr[7:0] == 8'h01) begin
                    wr.op = gx_bus_pkg::op_sec_rg;
                end else if ((bus.addr[7:0] & 8'hFE) == 8'h02) begin
                    wr.op = gx_bus_pkg::op_sec_commit;  // 7F03 mirrors 7F02
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== gx_video.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gx_config.svh"

module gx_video (
    input  wire                          clk_sys,
    input  wire                          reset,
    input  wire                          plus_mode,
    input  wire  [15:0]                  cpu_addr,
    input  wire  [7:0]                   cpu_data,
    input  wire                          cpu_wr,
    input  wire  [1:0]                   r_in,
    input  wire  [1:0]                   g_in,
    input  wire  [1:0]                   b_in,
    input  wire                          hsync,
    input  wire                          sprite_active,
    input  wire  [`GX_IDX_W-1:0]         sprite_pixel,
    output logic [`GX_COMP_W-1:0]        r_out,
    output logic [`GX_COMP_W-1:0]        g_out,
    output logic [`GX_COMP_W-1:0]        b_out,
    output gx_video_pkg::video_mode_t    mode,
    output logic                         rom_en
);

    gx_bus_pkg::cpu_bus_t     bus;
    gx_bus_pkg::reg_write_t   wr;
    gx_video_pkg::pixel_in_t  pix;
    gx_video_pkg::mrer_t      mrer;
    gx_video_pkg::color_t     pri_color;
    gx_video_pkg::color_t     sec_color;
    gx_video_pkg::color_t     rgb;
    logic [5:0]               rgb_idx;
    logic [`GX_IDX_W-1:0]     rd_a_idx;
    logic [`GX_IDX_W-1:0]     rd_b_idx;
    logic                     plus_active;
    logic                     enhanced_active;

    assign bus = '{addr: cpu_addr, data: cpu_data, wr: cpu_wr};

    // 6-bit index cut to 5 so the top red bit falls off
    assign rgb_idx = {r_in, g_in, b_in};
    assign pix     = '{color_idx: rgb_idx[`GX_IDX_W-1:0],
                       sprite_active: sprite_active,
                       sprite_pixel: sprite_pixel};

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    gx_reg_decode u_decode (
        .bus (bus),
        .wr  (wr)
    );

    gx_palette_bank u_bank (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .wr        (wr),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .pri_color (pri_color),
        .sec_color (sec_color)
    );

    gx_mrer_sync u_mrer (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .wr              (wr),
        .hsync           (hsync),
        .plus_mode       (plus_mode),
        .mrer            (mrer),
        .mode            (mode),
        .plus_active     (plus_active),
        .enhanced_active (enhanced_active)
    );

    gx_pixel_mux u_mux (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .pix             (pix),
        .plus_active     (plus_active),
        .enhanced_active (enhanced_active),
        .rd_a_idx        (rd_a_idx),
        .rd_b_idx        (rd_b_idx),
        .pri_color       (pri_color),
        .sec_color       (sec_color),
        .rgb_out         (rgb)
    );

    assign r_out  = rgb.red;
    assign g_out  = rgb.green;
    assign b_out  = rgb.blue;
    assign rom_en = mrer.rom_en;        // Changes only at an hsync edge

endmodule

`default_nettype wire

// ==== gx_video_pkg.sv ====
`default_nettype none

`include "gx_config.svh"

package gx_video_pkg;

    // 12-bit palette color
    typedef struct packed {
        logic [`GX_COMP_W-1:0] red;
        logic [`GX_COMP_W-1:0] green;
        logic [`GX_COMP_W-1:0] blue;
    } color_t;

    // Decoded video mode
    typedef enum logic [2:0] {
        mode_standard = 3'd0,
        mode_enhanced = 3'd1,
        mode_sprite   = 3'd2,
        mode_combined = 3'd3,       // Enhanced video plus sprites
        mode_audio    = 3'd4,
        mode_plus     = 3'd5        // MRER code 0C
    } video_mode_t;

    // Mode and ROM enable register
    typedef struct packed {
        logic [4:0] mode_code;      // Raw code from data bits 4..0
        logic       rom_en;         // Data bit 6
        logic       plus_en;        // Data bit 7
        logic       enhanced;       // Derived from the code
    } mrer_t;

    // Per-pixel input from video and sprite engine
    typedef struct packed {
        logic [`GX_IDX_W-1:0] color_idx;
        logic                 sprite_active;
        logic [`GX_IDX_W-1:0] sprite_pixel;
    } pixel_in_t;

endpackage

`default_nettype wire

// ==== tb_gx_video.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gx_config.svh"

module tb_gx_video;

    // One table row of stimulus and expected mode
    typedef struct packed {
        logic                      wr;
        logic [15:0]               addr;
        logic [7:0]                data;
        logic [5:0]                idx;         // {r,g,b} color index
        logic                      spr_act;
        logic [`GX_IDX_W-1:0]      spr_pix;
        logic                      plus;
        logic                      hsync;
        gx_video_pkg::video_mode_t exp_mode;
        logic                      exp_rom;
    } step_t;

    localparam gx_video_pkg::video_mode_t m_std  = gx_video_pkg::mode_standard;
    localparam gx_video_pkg::video_mode_t m_enh  = gx_video_pkg::mode_enhanced;
    localparam gx_video_pkg::video_mode_t m_plus = gx_video_pkg::mode_plus;

    logic                      clk_sys = 1'b0;
    logic                      reset;
    logic                      plus_mode;
    logic [15:0]               cpu_addr;
    logic [7:0]                cpu_data;
    logic                      cpu_wr;
    logic [1:0]                r_in;
    logic [1:0]                g_in;
    logic [1:0]                b_in;
    logic                      hsync;
    logic                      sprite_active;
    logic [`GX_IDX_W-1:0]      sprite_pixel;
    logic [`GX_COMP_W-1:0]     r_out;
    logic [`GX_COMP_W-1:0]     g_out;
    logic [`GX_COMP_W-1:0]     b_out;
    gx_video_pkg::video_mode_t mode;
    logic                      rom_en;
    gx_video_pkg::color_t      rgb_seen;

    step_t table_q[$];
    int    cycles = 0;
    int    cycle_limit = 1000;          // Replaced once the table is built
    int    passed = 0;
    int    failed = 0;
    logic  step_ok;

    //////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////

    gx_video_pkg::color_t ref_pri [0:`GX_PAL_ENTRIES-1];
    gx_video_pkg::color_t ref_sec [0:`GX_PAL_ENTRIES-1];
    logic [4:0]           ref_ptr;
    logic [3:0]           ref_lr;
    logic [3:0]           ref_lg;
    gx_video_pkg::mrer_t  ref_mrer;
    gx_video_pkg::mrer_t  ref_staged;
    logic                 ref_pending;

    always #20 clk_sys = ~clk_sys;      // 40 ns period

    assign rgb_seen = {r_out, g_out, b_out};

    gx_video UUT (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .plus_mode     (plus_mode),
        .cpu_addr      (cpu_addr),
        .cpu_data      (cpu_data),
        .cpu_wr        (cpu_wr),
        .r_in          (r_in),
        .g_in          (g_in),
        .b_in          (b_in),
        .hsync         (hsync),
        .sprite_active (sprite_active),
        .sprite_pixel  (sprite_pixel),
        .r_out         (r_out),
        .g_out         (g_out),
        .b_out         (b_out),
        .mode          (mode),
        .rom_en        (rom_en)
    );

    // Run limit
    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Codes 01..04 and 0C count as enhanced
    function automatic logic is_enhanced(input logic [4:0] code);
        return code inside {5'h01, 5'h02, 5'h03, 5'h04, 5'h0C};
    endfunction

    task automatic add_step(input logic wr, input logic [15:0] addr, input logic [7:0] data,
                            input logic [5:0] idx, input logic sa, input logic [4:0] sp,
                            input logic plus, input logic hs,
                            input gx_video_pkg::video_mode_t m, input logic rom);
        table_q.push_back('{wr, addr, data, idx, sa, sp, plus, hs, m, rom});
    endtask

    task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
        logic [4:0]          idx;
        gx_video_pkg::mrer_t req;
        idx = addr[5:1];
        req = '{mode_code: data[4:0], rom_en: data[6], plus_en: data[7],
                enhanced: is_enhanced(data[4:0])};
        if (addr >= 16'h6400 && addr <= 16'h643F) begin
            if (addr[0]) begin
                ref_pri[idx].red  = data[7:4];
                ref_pri[idx].blue = data[3:0];
            end else begin
                ref_pri[idx].green = data[3:0];
            end
        end else if (addr == 16'h7F00) begin
            ref_ptr = data[4:0];
        end else if (addr == 16'h7F01) begin
            ref_lr = data[7:4];
            ref_lg = data[3:0];
        end else if (addr == 16'h7F02 || addr == 16'h7F03) begin
            ref_sec[ref_ptr] = '{red: ref_lr, green: ref_lg, blue: data[7:4]};
            ref_ptr          = ref_ptr + 1'b1;      // Wraps 31 to 0
        end else if (addr == 16'h7F8C &&
                     {req.mode_code, req.rom_en, req.plus_en} !=
                     {ref_mrer.mode_code, ref_mrer.rom_en, ref_mrer.plus_en}) begin
            ref_staged  = req;
            ref_pending = 1'b1;
        end
    endtask

    // Color the pins should show for one row
    function automatic gx_video_pkg::color_t expected_color(input step_t s);
        logic [4:0] eff;
        eff = s.spr_act ? s.spr_pix : s.idx[4:0];   // Top red bit dropped
        if (s.plus || ref_mrer.plus_en)
            return ref_sec[eff];
        if (ref_mrer.enhanced && s.spr_act)
            return ref_sec[s.spr_pix];
        return ref_pri[eff[3:0]];
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_color(input string name, input gx_video_pkg::color_t got,
                               input gx_video_pkg::color_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            step_ok = 1'b0;
        end
    endtask

    task automatic check_mode(input string name, input gx_video_pkg::video_mode_t got,
                              input gx_video_pkg::video_mode_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            step_ok = 1'b0;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            step_ok = 1'b0;
        end
    endtask

    task automatic build_table();
        add_step(0, 16'h0000, 8'h00, 6'd0,  0, 5'd0,  0, 0, m_std, 0);  // Reset state
        add_step(1, 16'h6406, 8'h05, 6'd3,  0, 5'd0,  0, 0, m_std, 0);  // Entry 3 green
        add_step(1, 16'h6407, 8'hA3, 6'd3,  0, 5'd0,  0, 0, m_std, 0);  // Entry 3 red and blue
        add_step(1, 16'h6408, 8'h0B, 6'd4,  0, 5'd0,  0, 0, m_std, 0);
        add_step(1, 16'h6409, 8'hC2, 6'd20, 0, 5'd0,  0, 0, m_std, 0);  // 20 reads entry 4
        add_step(0, 16'h0000, 8'h00, 6'h34, 0, 5'd0,  0, 0, m_std, 0);  // 6-bit index cut
        add_step(1, 16'h6428, 8'h0F, 6'd20, 0, 5'd0,  0, 0, m_std, 0);
        add_step(1, 16'h6429, 8'hFF, 6'd20, 0, 5'd0,  0, 0, m_std, 0);
        // Secondary palette through the pointer
        add_step(1, 16'h7F00, 8'h05, 6'd0,  0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F01, 8'h9C, 6'd5,  0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F02, 8'h70, 6'd5,  0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F01, 8'h36, 6'd5,  0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F03, 8'hE0, 6'd6,  0, 5'd0,  1, 0, m_std, 0);
        add_step(0, 16'h0000, 8'h00, 6'd0,  1, 5'd6,  1, 0, m_std, 0);  // Sprite in plus
        add_step(1, 16'h7F00, 8'h1F, 6'd31, 0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F01, 8'h11, 6'd31, 0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F02, 8'h20, 6'd31, 0, 5'd0,  1, 0, m_std, 0);
        add_step(1, 16'h7F02, 8'h30, 6'd0,  0, 5'd0,  1, 0, m_std, 0);  // Pointer wrapped
        // MRER waits for hsync
        add_step(1, 16'h7F8C, 8'h41, 6'd3,  0, 5'd0,  0, 0, m_std, 0);
        add_step(0, 16'h0000, 8'h00, 6'd3,  0, 5'd0,  0, 0, m_std, 0);
        add_step(0, 16'h0000, 8'h00, 6'd3,  0, 5'd0,  0, 1, m_enh, 1);
        add_step(0, 16'h0000, 8'h00, 6'd3,  1, 5'd5,  0, 0, m_enh, 1);  // Sprite from secondary
        add_step(0, 16'h0000, 8'h00, 6'h13, 0, 5'd0,  0, 0, m_enh, 1);  // Background 19 as 3
        add_step(0, 16'h0000, 8'h00, 6'd0,  1, 5'd31, 0, 0, m_enh, 1);
        add_step(1, 16'h7F8C, 8'h07, 6'd3,  0, 5'd0,  0, 0, m_enh, 1);  // Unknown code
        add_step(0, 16'h0000, 8'h00, 6'd3,  0, 5'd0,  0, 1, m_std, 0);
        add_step(0, 16'h0000, 8'h00, 6'd0,  1, 5'd19, 0, 0, m_std, 0);
        add_step(1, 16'h7F8C, 8'h41, 6'd3,  0, 5'd0,  0, 0, m_std, 0);
        add_step(1, 16'h7F8C, 8'h07, 6'd3,  0, 5'd0,  0, 0, m_std, 0);  // Same as current
        add_step(0, 16'h0000, 8'h00, 6'd3,  0, 5'd0,  0, 1, m_enh, 1);  // Staged 41 survives
        add_step(1, 16'h7F8C, 8'h8C, 6'd5,  0, 5'd0,  0, 0, m_enh, 1);
        add_step(0, 16'h0000, 8'h00, 6'd5,  0, 5'd0,  0, 1, m_plus, 0); // Plus bit set
    endtask

    initial begin
        step_t                s;
        gx_video_pkg::color_t exp_color;
        build_table();
        cycle_limit = table_q.size() * 8 + 100;
        reset         <= 1'b1;
        plus_mode     <= 1'b0;
        cpu_addr      <= '0;
        cpu_data      <= '0;
        cpu_wr        <= 1'b0;
        {r_in, g_in, b_in} <= '0;
        hsync         <= 1'b0;
        sprite_active <= 1'b0;
        sprite_pixel  <= '0;
        foreach (ref_pri[i]) begin
            ref_pri[i] = '0;
            ref_sec[i] = '0;
        end
        ref_ptr     = '0;
        ref_lr      = '0;
        ref_lg      = '0;
        ref_mrer    = '0;
        ref_staged  = '0;
        ref_pending = 1'b0;
        repeat (10) @(posedge clk_sys);
        reset <= 1'b0;

        foreach (table_q[i]) begin
            s = table_q[i];
            @(posedge clk_sys);
            cpu_wr        <= s.wr;
            cpu_addr      <= s.addr;
            cpu_data      <= s.data;
            {r_in, g_in, b_in} <= s.idx;
            sprite_active <= s.spr_act;
            sprite_pixel  <= s.spr_pix;
            plus_mode     <= s.plus;
            hsync         <= s.hsync;
            @(posedge clk_sys);             // Write and hsync land here
            cpu_wr <= 1'b0;
            hsync  <= 1'b0;
            if (s.hsync && ref_pending) begin
                ref_mrer    = ref_staged;
                ref_pending = 1'b0;
            end
            if (s.wr)
                model_write(s.addr, s.data);
            @(posedge clk_sys);             // Output register catches up
            @(negedge clk_sys);
            exp_color = expected_color(s);
            step_ok   = 1'b1;
            check_color("rgb_out", rgb_seen, exp_color);
            check_mode("mode", mode, s.exp_mode);
            check_bit("rom_en", rom_en, s.exp_rom);
            if (step_ok)
                passed++;
            else
                failed++;
            $display("Step %0d %s", i, step_ok ? "ok" : "FAILED");
        end

        $display("%0d steps run, %0d passed, %0d failed", table_q.size(), passed, failed);
        if (failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
gx_bus_pkg.sv
gx_video_pkg.sv
gx_reg_decode.sv
gx_palette_bank.sv
gx_mrer_sync.sv
gx_pixel_mux.sv
gx_video.sv
tb_gx_video.sv
